// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module tb_dsp_core

run: build
	./obj_dir/Vtb_dsp_core > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "RESULT: FAIL" sim.log

lint:
	verilator --lint-only --timing -f verilog.f --top-module tb_dsp_core

clean:
	rm -rf obj_dir sim.log

// ==== alu_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface alu_if
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;
();
	logic req_valid;
	logic req_ready;
	opcode_e op;
	sample_t a;
	sample_t b;
	sample_t c;
	shift_t shift;
	logic saturate;

	// single-cycle pulse, always taken by the sequencer.
	logic res_valid;
	sample_t res;

	modport seq (output req_valid, op, a, b, c, shift, saturate, input req_ready, res_valid, res);
	modport alu (input req_valid, op, a, b, c, shift, saturate, output req_ready, res_valid, res);
endinterface

`default_nettype wire

// ==== block_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_alu
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;
(
	input logic clk,
	input logic reset,
	alu_if.alu alu
);

	localparam sample_t sample_max = {1'b0, {(data_width-1){1'b1}}};
	localparam sample_t sample_min = {1'b1, {(data_width-1){1'b0}}};

	logic accept;
	logic is_mul_op;
	logic [2:0] stage_v; // product, shift and narrow stages; bit 2 is the MAD add.
	logic mad_q;
	logic sat_q;
	shift_t shift_q;
	sample_t c_q;
	product_t prod_q;
	product_t shifted_q;
	sample_t mul_q;

	// both operands are widened by one bit so the sum cannot overflow.
	function automatic sample_t add_path(sample_t x, sample_t y, logic sub, logic sat);
		logic signed [data_width:0] xw;
		logic signed [data_width:0] yw;
		logic signed [data_width:0] sum;
		xw = x;
		yw = y;
		sum = sub ? xw - yw : xw + yw;
		if (sat && sum > sample_max) return sample_max;
		if (sat && sum < sample_min) return sample_min;
		return sum[data_width-1:0];
	endfunction

	function automatic sample_t narrow(product_t v, logic sat);
		if (sat && v > sample_max) return sample_max;
		if (sat && v < sample_min) return sample_min;
		return v[data_width-1:0];
	endfunction

	assign accept = alu.req_valid && alu.req_ready;
	assign is_mul_op = (alu.op == MUL) || (alu.op == MAD);
	assign alu.req_ready = !(|stage_v);

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_v <= '0;
			alu.res_valid <= 1'b0;
		end else begin
			stage_v[0] <= accept && is_mul_op;
			stage_v[1] <= stage_v[0];
			stage_v[2] <= stage_v[1] && mad_q;
			alu.res_valid <= (accept && !is_mul_op) || (stage_v[1] && !mad_q) || stage_v[2];
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			mad_q <= (alu.op == MAD);
			sat_q <= alu.saturate;
			shift_q <= alu.shift;
			c_q <= alu.c;
			case (alu.op)
				MOV: alu.res <= alu.a;
				ABS: alu.res <= alu.a[data_width-1] ? -alu.a : alu.a; // the most negative value wraps.
				ARSH: alu.res <= alu.a >>> 1;
				ADD: alu.res <= add_path(alu.a, alu.b, 1'b0, alu.saturate);
				SUB: alu.res <= add_path(alu.a, alu.b, 1'b1, alu.saturate);
				MUL, MAD: prod_q <= alu.a * alu.b;
				default: alu.res <= alu.a;
			endcase
		end
		if (stage_v[0]) begin
			// a shift of 0 keeps the Q1.15 scaling of the product.
			shifted_q <= prod_q >>> (data_width - 1 - int'(shift_q));
		end
		if (stage_v[1]) begin
			if (mad_q) begin
				mul_q <= narrow(shifted_q, sat_q);
			end else begin
				alu.res <= narrow(shifted_q, sat_q);
			end
		end
		if (stage_v[2]) begin
			alu.res <= add_path(mul_q, c_q, 1'b0, sat_q);
		end
	end

endmodule

`default_nettype wire

// ==== block_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_sequencer
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;
#(
	parameter int n_blocks = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input instr_t instr,
	input logic [$clog2(n_blocks)-1:0] last_block,
	output logic [$clog2(n_blocks)-1:0] read_block,
	output logic ready,
	operand_if.seq ops,
	alu_if.seq alu
);

	localparam int block_w = $clog2(n_blocks);

	seq_state_e state;
	logic [block_w-1:0] current_block;
	logic [1:0] operand_idx;
	logic [1:0] operand_cnt;
	instr_t instr_q;
	sample_t a;
	sample_t b;
	sample_t c;

	always_comb begin
		case (instr_q.op)
			ADD, SUB, MUL: operand_cnt = 2'd2;
			MAD: operand_cnt = 2'd3;
			default: operand_cnt = 2'd1;
		endcase
	end

	assign read_block = current_block;

	always_comb begin
		ops.rd_block = current_block;
		case (operand_idx)
			2'd0: begin
				ops.rd_is_reg = instr_q.src_a_reg;
				ops.rd_addr = instr_q.src_a;
			end
			2'd1: begin
				ops.rd_is_reg = instr_q.src_b_reg;
				ops.rd_addr = instr_q.src_b;
			end
			default: begin
				ops.rd_is_reg = instr_q.src_c_reg;
				ops.rd_addr = instr_q.src_c;
			end
		endcase
		if (state == FINISH) begin
			ops.rd_is_reg = 1'b0; // channel 0 carries the output sample.
			ops.rd_addr = '0;
		end
	end

	// the result is written back in the cycle it arrives.
	assign ops.wr_en = (state == WAIT_RES) && alu.res_valid;
	assign ops.wr_block = current_block;
	assign ops.wr_is_reg = instr_q.dest_reg;
	assign ops.wr_addr = instr_q.dest;
	assign ops.wr_data = alu.res;

	assign alu.req_valid = (state == ISSUE);
	assign alu.op = instr_q.op;
	assign alu.a = a;
	assign alu.b = b;
	assign alu.c = c;
	assign alu.shift = instr_q.shift;
	assign alu.saturate = instr_q.saturate;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			ready <= 1'b1;
			current_block <= '0;
			operand_idx <= '0;
		end else begin
			case (state)
				IDLE: if (tick) begin
					current_block <= '0;
					ready <= 1'b0;
					state <= INSTR;
				end
				INSTR: state <= DECODE; // instruction read is in flight.
				DECODE: begin
					operand_idx <= '0;
					state <= (instr.op == NOP) ? NEXT : FETCH_ADDR;
				end
				FETCH_ADDR: state <= FETCH_DATA;
				FETCH_DATA: begin
					if (operand_idx == operand_cnt - 2'd1) begin
						state <= ISSUE;
					end else begin
						operand_idx <= operand_idx + 2'd1;
						state <= FETCH_ADDR;
					end
				end
				ISSUE: if (alu.req_ready) state <= WAIT_RES;
				WAIT_RES: if (alu.res_valid) state <= NEXT;
				NEXT: begin
					if (current_block == last_block || current_block == block_w'(n_blocks - 1)) begin
						state <= FINISH;
					end else begin
						current_block <= current_block + 1'b1;
						state <= INSTR;
					end
				end
				FINISH: begin
					ready <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == DECODE) begin
			instr_q <= instr;
		end
		if (state == FETCH_DATA) begin
			case (operand_idx)
				2'd0: a <= ops.rd_data;
				2'd1: b <= ops.rd_data;
				default: c <= ops.rd_data;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== dsp_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module dsp_core
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;
#(
	parameter int n_blocks = 16,
	parameter int n_registers = 16,
	parameter int n_channels = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input sample_t sample_in,
	input logic cmd_instr_write,
	input logic cmd_reg_write,
	input logic [$clog2(n_blocks)-1:0] cmd_block,
	input reg_addr_t cmd_reg,
	input instr_t cmd_instr,
	input sample_t cmd_reg_data,
	output sample_t sample_out,
	output logic ready
);

	logic [$clog2(n_blocks)-1:0] read_block;
	logic [$clog2(n_blocks)-1:0] last_block;
	instr_t instr;

	operand_if #(.n_blocks(n_blocks)) ops_bus ();
	alu_if alu_bus ();

	instr_store #(.n_blocks(n_blocks)) instr_store_inst (
		.clk(clk),
		.reset(reset),
		.write(cmd_instr_write),
		.write_block(cmd_block),
		.write_instr(cmd_instr),
		.read_block(read_block),
		.instr(instr),
		.last_block(last_block)
	);

	operand_store #(
		.n_blocks(n_blocks),
		.n_registers(n_registers),
		.n_channels(n_channels)
	) operand_store_inst (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.ready(ready),
		.sample_in(sample_in),
		.cmd_write(cmd_reg_write),
		.cmd_block(cmd_block),
		.cmd_reg(cmd_reg),
		.cmd_data(cmd_reg_data),
		.ops(ops_bus.store),
		.sample_out(sample_out)
	);

	block_sequencer #(.n_blocks(n_blocks)) block_sequencer_inst (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.instr(instr),
		.last_block(last_block),
		.read_block(read_block),
		.ready(ready),
		.ops(ops_bus.seq),
		.alu(alu_bus.seq)
	);

	block_alu block_alu_inst (
		.clk(clk),
		.reset(reset),
		.alu(alu_bus.alu)
	);

endmodule

`default_nettype wire

// ==== dsp_core_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module dsp_core_sva
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic ready,
	input logic req_valid,
	input logic req_ready,
	input logic res_valid,
	input opcode_e op,
	input sample_t a,
	input sample_t b,
	input sample_t c,
	input shift_t shift,
	input logic saturate,
	input logic wr_en
);

	logic pending; // an accepted request still waits for its result.

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (req_valid && req_ready) begin
			pending <= 1'b1;
		end else if (res_valid) begin
			pending <= 1'b0;
		end
	end

	req_held: assert property (@(posedge clk) disable iff (reset)
		req_valid && !req_ready |=> req_valid && $stable(op) && $stable(a) && $stable(b)
			&& $stable(c) && $stable(shift) && $stable(saturate))
		else $error("alu request dropped or changed before it was accepted");

	res_after_req: assert property (@(posedge clk) disable iff (reset) res_valid |-> pending)
		else $error("alu result without an accepted request");

	no_write_idle: assert property (@(posedge clk) disable iff (reset) !(wr_en && ready))
		else $error("operand write while the core is idle");

endmodule

bind dsp_core dsp_core_sva dsp_core_sva_inst (
	.clk(clk),
	.reset(reset),
	.ready(ready),
	.req_valid(alu_bus.req_valid),
	.req_ready(alu_bus.req_ready),
	.res_valid(alu_bus.res_valid),
	.op(alu_bus.op),
	.a(alu_bus.a),
	.b(alu_bus.b),
	.c(alu_bus.c),
	.shift(alu_bus.shift),
	.saturate(alu_bus.saturate),
	.wr_en(ops_bus.wr_en)
);

`default_nettype wire

// ==== dsp_isa_pkg.sv ====
`default_nettype none

package dsp_isa_pkg;
	import dsp_types_pkg::*;

	typedef enum logic [3:0] {
		NOP  = 4'd0,
		MOV  = 4'd1,
		ABS  = 4'd2,
		ARSH = 4'd3,
		ADD  = 4'd4,
		SUB  = 4'd5,
		MUL  = 4'd6,
		MAD  = 4'd7
	} opcode_e;

	// a 1 in a *_reg bit selects the block registers, a 0 the shared channels.
	typedef struct packed {
		opcode_e   op;
		reg_addr_t src_a;
		reg_addr_t src_b;
		reg_addr_t src_c;
		reg_addr_t dest;
		logic      src_a_reg;
		logic      src_b_reg;
		logic      src_c_reg;
		logic      dest_reg;
		logic      saturate;
		shift_t    shift;
		logic [2:0] spare;
	} instr_t;

	typedef enum logic [3:0] {
		IDLE, INSTR, DECODE, FETCH_ADDR, FETCH_DATA, ISSUE, WAIT_RES, NEXT, FINISH
	} seq_state_e;

endpackage

`default_nettype wire

// ==== dsp_types_pkg.sv ====
`default_nettype none

package dsp_types_pkg;

	// width of one audio sample; the types below all derive from it.
	localparam int data_width = 16;

	typedef logic signed [data_width-1:0] sample_t;

	// a full-width product, before the fractional shift.
	typedef logic signed [2*data_width-1:0] product_t;

	typedef logic [3:0] shift_t;

	// register or channel index inside one block.
	typedef logic [3:0] reg_addr_t;

endpackage

`default_nettype wire

// ==== instr_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_store
	import dsp_isa_pkg::*;
#(
	parameter int n_blocks = 16
) (
	input logic clk,
	input logic reset,
	input logic write,
	input logic [$clog2(n_blocks)-1:0] write_block,
	input instr_t write_instr,
	input logic [$clog2(n_blocks)-1:0] read_block,
	output instr_t instr,
	output logic [$clog2(n_blocks)-1:0] last_block
);

	instr_t mem [n_blocks];

	always_ff @(posedge clk) begin
		if (write) begin
			mem[write_block] <= write_instr;
		end
		instr <= mem[read_block]; // one cycle read latency.
	end

	// the run length follows the highest block the host has written.
	always_ff @(posedge clk) begin
		if (reset) begin
			last_block <= '0;
		end else if (write && write_block > last_block) begin
			last_block <= write_block;
		end
	end

endmodule

`default_nettype wire

// ==== operand_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface operand_if
	import dsp_types_pkg::*;
#(
	parameter int n_blocks = 16
) ();
	logic [$clog2(n_blocks)-1:0] rd_block;
	logic rd_is_reg;
	reg_addr_t rd_addr;
	sample_t rd_data; // valid one cycle after the address.
	logic wr_en;
	logic [$clog2(n_blocks)-1:0] wr_block;
	logic wr_is_reg;
	reg_addr_t wr_addr;
	sample_t wr_data;

	modport seq (output rd_block, rd_is_reg, rd_addr, wr_en, wr_block, wr_is_reg, wr_addr,
		wr_data, input rd_data);
	modport store (input rd_block, rd_is_reg, rd_addr, wr_en, wr_block, wr_is_reg, wr_addr,
		wr_data, output rd_data);
endinterface

`default_nettype wire

// ==== operand_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_store
	import dsp_types_pkg::*;
#(
	parameter int n_blocks = 16,
	parameter int n_registers = 16,
	parameter int n_channels = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic ready,
	input sample_t sample_in,
	input logic cmd_write,
	input logic [$clog2(n_blocks)-1:0] cmd_block,
	input reg_addr_t cmd_reg,
	input sample_t cmd_data,
	operand_if.store ops,
	output sample_t sample_out
);

	sample_t regs [n_blocks][n_registers];
	sample_t channels [n_channels];
	sample_t sample_q;
	logic ready_q;
	logic ready_rise;

	assign ready_rise = ready && !ready_q;

	// a block write from the sequencer wins over a host preset.
	always_ff @(posedge clk) begin
		if (ops.wr_en && ops.wr_is_reg) begin
			regs[ops.wr_block][ops.wr_addr] <= ops.wr_data;
		end else if (cmd_write) begin
			regs[cmd_block][cmd_reg] <= cmd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++) begin
				channels[i] <= '0;
			end
		end else if (ops.wr_en && !ops.wr_is_reg) begin
			channels[ops.wr_addr] <= ops.wr_data;
		end else if (tick && ready) begin
			channels[0] <= sample_in; // ticks during a run are ignored.
		end
	end

	always_ff @(posedge clk) begin
		ops.rd_data <= ops.rd_is_reg ? regs[ops.rd_block][ops.rd_addr] : channels[ops.rd_addr];
		if (ready_rise) begin
			sample_q <= ops.rd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ready_q <= 1'b1;
		end else begin
			ready_q <= ready;
		end
	end

	// the final channel 0 read lands on the same edge that raises ready.
	assign sample_out = ready_rise ? ops.rd_data : sample_q;

endmodule

`default_nettype wire

// ==== tb_dsp_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dsp_core
	import dsp_types_pkg::*;
	import dsp_isa_pkg::*;
();

	localparam int n_blocks = 16;
	localparam int tick_budget = 80;
	localparam int cmd_budget = 1500;
	localparam int timeout_cycles = tick_budget * n_blocks * 12 + cmd_budget + 200;

	logic clk = 1'b0;
	logic reset;
	logic tick;
	sample_t sample_in;
	logic cmd_instr_write;
	logic cmd_reg_write;
	logic [$clog2(n_blocks)-1:0] cmd_block;
	reg_addr_t cmd_reg;
	instr_t cmd_instr;
	sample_t cmd_reg_data;
	sample_t sample_out;
	logic ready;

	int seed = 32'h81fe;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	sample_t exp_q [$];

	// reference copies of the core state.
	sample_t m_regs [n_blocks][16];
	sample_t m_chan [16];
	instr_t m_prog [n_blocks];
	int m_last = 0;

	dsp_core #(.n_blocks(n_blocks)) dsp_core_inst (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: the core did not finish within %0d cycles", timeout_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic sample_t clamp(longint v);
		if (v > 32767) return 16'sd32767;
		if (v < -32768) return -16'sd32768;
		return sample_t'(v);
	endfunction

	function automatic sample_t execute(instr_t ins, sample_t a, sample_t b, sample_t c);
		longint p;
		int s;
		sample_t m;
		case (ins.op)
			ABS: return sample_t'(a < 0 ? -int'(a) : int'(a)); // -32768 wraps to itself.
			ARSH: return sample_t'(int'(a) >>> 1);
			ADD, SUB: begin
				s = (ins.op == ADD) ? int'(a) + int'(b) : int'(a) - int'(b);
				return ins.saturate ? clamp(longint'(s)) : sample_t'(s);
			end
			MUL, MAD: begin
				p = (longint'(a) * longint'(b)) >>> (15 - int'(ins.shift));
				m = ins.saturate ? clamp(p) : sample_t'(p);
				if (ins.op == MUL) return m;
				s = int'(m) + int'(c);
				return ins.saturate ? clamp(longint'(s)) : sample_t'(s);
			end
			default: return a;
		endcase
	endfunction

	function automatic sample_t model_tick(sample_t s);
		instr_t ins;
		sample_t a;
		sample_t b;
		sample_t c;
		sample_t r;
		m_chan[0] = s;
		for (int blk = 0; blk <= m_last; blk++) begin
			ins = m_prog[blk];
			if (ins.op != NOP) begin
				a = ins.src_a_reg ? m_regs[blk][ins.src_a] : m_chan[ins.src_a];
				b = ins.src_b_reg ? m_regs[blk][ins.src_b] : m_chan[ins.src_b];
				c = ins.src_c_reg ? m_regs[blk][ins.src_c] : m_chan[ins.src_c];
				r = execute(ins, a, b, c);
				if (ins.dest_reg) m_regs[blk][ins.dest] = r;
				else m_chan[ins.dest] = r;
			end
		end
		return m_chan[0];
	endfunction

	function automatic instr_t make_instr(opcode_e op, logic a_reg, reg_addr_t a, logic b_reg,
			reg_addr_t b, logic c_reg, reg_addr_t c, logic d_reg, reg_addr_t d, logic sat,
			shift_t sh);
		instr_t ins;
		ins = '0;
		ins.op = op;
		ins.src_a_reg = a_reg;
		ins.src_a = a;
		ins.src_b_reg = b_reg;
		ins.src_b = b;
		ins.src_c_reg = c_reg;
		ins.src_c = c;
		ins.dest_reg = d_reg;
		ins.dest = d;
		ins.saturate = sat;
		ins.shift = sh;
		return ins;
	endfunction

	task automatic check_sample(sample_t got, sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: sample_out is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_ready(logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: ready is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic load_instr(int blk, instr_t ins);
		@(posedge clk);
		cmd_instr_write <= 1'b1;
		cmd_block <= blk[3:0];
		cmd_instr <= ins;
		@(posedge clk);
		cmd_instr_write <= 1'b0;
		m_prog[blk] = ins;
		if (blk > m_last) m_last = blk;
	endtask

	task automatic preset_reg(int blk, reg_addr_t r, sample_t v);
		@(posedge clk);
		cmd_reg_write <= 1'b1;
		cmd_block <= blk[3:0];
		cmd_reg <= r;
		cmd_reg_data <= v;
		@(posedge clk);
		cmd_reg_write <= 1'b0;
		m_regs[blk][r] = v;
	endtask

	task automatic run_tick(sample_t s);
		@(posedge clk);
		tick <= 1'b1;
		sample_in <= s;
		exp_q.push_back(model_tick(s));
		@(posedge clk);
		tick <= 1'b0;
		@(negedge clk);
		check_ready(ready, 1'b0); // a run takes many cycles, so ready must be low here.
		while (!ready) @(negedge clk);
		@(negedge clk);
	endtask

	// compares each finished run against the model.
	initial begin
		@(negedge reset); // ready also rises when reset first takes hold.
		forever begin
			@(posedge ready);
			@(negedge clk);
			if (exp_q.size() == 0) begin
				errors++;
				$display("ready rose at %0t without a pending tick", $time);
			end else begin
				check_sample(sample_out, exp_q.pop_front());
			end
		end
	end

	initial begin
		shift_t shifts [4];
		instr_t ins;
		logic [31:0] r;
		int n;
		shifts = '{4'd0, 4'd1, 4'd4, 4'd15};
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		cmd_instr_write = 1'b0;
		cmd_reg_write = 1'b0;
		cmd_block = '0;
		cmd_reg = '0;
		cmd_instr = '0;
		cmd_reg_data = '0;
		for (int i = 0; i < 16; i++) m_chan[i] = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_ready(ready, 1'b1);
		for (int blk = 0; blk < n_blocks; blk++) begin
			for (int i = 0; i < 16; i++) preset_reg(blk, reg_addr_t'(i), '0);
		end

		load_instr(0, make_instr(MOV, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0));
		run_tick(16'sd1234);

		for (int i = 0; i < 4; i++) begin
			preset_reg(0, 0, 16'sd30000);
			load_instr(0, make_instr(i < 2 ? ADD : SUB, 0, 0, 1, 0, 0, 0, 0, 0, i[0], 0));
			run_tick(i < 2 ? 16'sd10000 : -16'sd10000);
		end

		preset_reg(0, 1, 16'sd20000);
		preset_reg(0, 2, -16'sd25000);
		for (int i = 0; i < 8; i++) begin
			ins = make_instr(i < 4 ? MUL : MAD, 0, 0, 1, 1, 1, 2, 0, 0, i[0], shifts[i % 4]);
			load_instr(0, ins);
			run_tick(i[1] ? -16'sd30000 : 16'sd30000);
		end

		load_instr(0, make_instr(ABS, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
		run_tick(-16'sd32768);
		run_tick(-16'sd5);
		load_instr(0, make_instr(ARSH, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
		run_tick(-16'sd7);
		load_instr(0, make_instr(NOP, 0, 0, 0, 0, 0, 0, 0, 5, 0, 0));
		run_tick(16'sd77);
		preset_reg(0, 3, '0);
		load_instr(0, make_instr(ADD, 0, 0, 1, 3, 0, 0, 1, 3, 1, 0));
		run_tick(16'sd100);
		run_tick(16'sd200);
		run_tick(16'sd300);
		load_instr(0, make_instr(MOV, 1, 3, 0, 0, 0, 0, 0, 0, 0, 0)); // expect the sum 600.
		run_tick('0);

		for (int p = 0; p < 5; p++) begin
			n = 1 + ($unsigned($random(seed)) % 8);
			for (int blk = 0; blk < n; blk++) begin
				r = $random(seed);
				ins = r;
				ins.op = opcode_e'({1'b0, r[30:28]});
				ins.spare = '0;
				load_instr(blk, ins);
			end
			for (int k = 0; k < 8; k++) begin
				r = $random(seed);
				preset_reg($unsigned($random(seed)) % n, r[19:16], sample_t'(r[15:0]));
			end
			for (int t = 0; t < 8; t++) begin
				r = $random(seed);
				run_tick(sample_t'(r[15:0]));
			end
		end

		@(negedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d runs never raised ready", exp_q.size());
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
dsp_types_pkg.sv
dsp_isa_pkg.sv
operand_if.sv
alu_if.sv
instr_store.sv
operand_store.sv
block_alu.sv
block_sequencer.sv
dsp_core.sv
dsp_core_sva.sv
tb_dsp_core.sv
